// ==== include/fetch_consts.svh ====
/*
  sizing constants for the fetch front end
  memory depth must be a power of two, prefetch depth 2 or 4
  boot address is assumed word aligned
*/
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// 32-bit words in the instruction memory
`define FETCH_MEM_WORDS 256
// word address width, derived from the depth
`define FETCH_MEM_AW ($clog2(`FETCH_MEM_WORDS))
// pc after reset and first fetch address
`define FETCH_BOOT_ADDR 32'h0000_0000
// prefetch FIFO entries
`define FETCH_PF_DEPTH 2

`endif

// ==== hw/fetch_pkg.sv ====
/*
  shared types of the fetch front end
  memory requests carry word addresses, never byte addresses
*/
`default_nettype none

`include "fetch_consts.svh"

package fetch_pkg;

  // one request to the single-port memory
  typedef struct packed {
    logic                       valid;
    logic                       we;
    logic [`FETCH_MEM_AW-1:0]   addr;
    logic [31:0]                wdata;
  } mem_req_t;

  // read data, valid one cycle after a granted read
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } mem_rsp_t;

  // aligned instruction towards decode
  // compressed ones are zero-extended, not expanded
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic        compressed;
  } instr_pkt_t;

  typedef enum logic [1:0] {ALIGNED, RESIDUE16, RESIDUE32, BRANCH_HALF} align_state_e;

  typedef enum logic [1:0] {OWNER_NONE, OWNER_HOST, OWNER_FETCH} arb_owner_e;

  typedef enum logic [1:0] {AX_IDLE, AX_READ, AX_RESP_R, AX_RESP_B} axil_state_e;

endpackage

`default_nettype wire

// ==== hw/instr_mem.sv ====
/*
  single-port word memory, one-cycle read latency
  no reset on the array, contents are undefined until loaded
*/
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module instr_mem import fetch_pkg::*; (
  input  logic     clk,
  input  mem_req_t req_i,
  output mem_rsp_t rsp_o
);

  logic [31:0] mem_q [`FETCH_MEM_WORDS];
  mem_rsp_t    rsp_q;

  always_ff @(posedge clk) begin
    if (req_i.valid && req_i.we) begin
      mem_q[req_i.addr] <= req_i.wdata;
    end
    // response valid only for reads
    rsp_q.valid <= req_i.valid && !req_i.we;
    if (req_i.valid && !req_i.we) begin
      rsp_q.data <= mem_q[req_i.addr];
    end
  end

  assign rsp_o = rsp_q;

endmodule

`default_nettype wire

// ==== hw/mem_arbiter.sv ====
/*
  fixed-priority arbiter for the single memory port
  host always wins, fetch side waits with its request held
  read data is steered by the owner registered at grant time
*/
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import fetch_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  mem_req_t host_req_i,
  input  mem_req_t fetch_req_i,
  output logic     host_gnt_o,
  output logic     fetch_gnt_o,
  output mem_rsp_t host_rsp_o,
  output mem_rsp_t fetch_rsp_o,
  output mem_req_t mem_req_o,
  input  mem_rsp_t mem_rsp_i
);

  arb_owner_e owner_q, owner_d;

  always_comb begin
    host_gnt_o  = 1'b0;
    fetch_gnt_o = 1'b0;
    mem_req_o   = '0;
    owner_d     = OWNER_NONE;
    if (host_req_i.valid) begin
      host_gnt_o = 1'b1;
      mem_req_o  = host_req_i;
      // writes return nothing, so no owner to remember
      if (!host_req_i.we) owner_d = OWNER_HOST;
    end else if (fetch_req_i.valid) begin
      fetch_gnt_o = 1'b1;
      mem_req_o   = fetch_req_i;
      if (!fetch_req_i.we) owner_d = OWNER_FETCH;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owner_q <= OWNER_NONE;
    end else begin
      owner_q <= owner_d;
    end
  end

  // data goes to both, valid only to the owner
  assign host_rsp_o.valid  = mem_rsp_i.valid && (owner_q == OWNER_HOST);
  assign host_rsp_o.data   = mem_rsp_i.data;
  assign fetch_rsp_o.valid = mem_rsp_i.valid && (owner_q == OWNER_FETCH);
  assign fetch_rsp_o.data  = mem_rsp_i.data;

endmodule

`default_nettype wire

// ==== hw/axil_mem_port.sv ====
/*
  AXI4-Lite slave onto the memory request port, one transaction at a time
  a write is taken only with aw and w valid together, writes beat reads
  strobes are not supported, responses are always OKAY
  addresses above the memory size wrap
*/
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module axil_mem_port import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [31:0] awaddr_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  input  logic [31:0] wdata_i,
  output logic        bvalid_o,
  input  logic        bready_i,
  output logic [1:0]  bresp_o,
  input  logic        arvalid_i,
  output logic        arready_o,
  input  logic [31:0] araddr_i,
  output logic        rvalid_o,
  input  logic        rready_i,
  output logic [31:0] rdata_o,
  output logic [1:0]  rresp_o,
  output mem_req_t    req_o,
  input  logic        gnt_i,
  input  mem_rsp_t    rsp_i
);

  axil_state_e              state_q;
  logic                     pend_q;
  logic                     we_q;
  logic [`FETCH_MEM_AW-1:0] addr_q;
  logic [31:0]              wdata_q;
  logic [31:0]              rdata_q;
  logic                     wr_acc;
  logic                     rd_acc;

  // idle accepts, write pair first
  assign wr_acc    = (state_q == AX_IDLE) && awvalid_i && wvalid_i;
  assign arready_o = (state_q == AX_IDLE) && !(awvalid_i && wvalid_i);
  assign rd_acc    = arready_o && arvalid_i;
  assign awready_o = wr_acc;
  assign wready_o  = wr_acc;

  // request held until the arbiter grants it
  assign req_o.valid = pend_q;
  assign req_o.we    = we_q;
  assign req_o.addr  = addr_q;
  assign req_o.wdata = wdata_q;

  assign bvalid_o = (state_q == AX_RESP_B) && !pend_q;
  assign bresp_o  = 2'b00;
  assign rvalid_o = (state_q == AX_RESP_R);
  assign rdata_o  = rdata_q;
  assign rresp_o  = 2'b00;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= AX_IDLE;
      pend_q  <= 1'b0;
    end else begin
      case (state_q)
        AX_IDLE: begin
          if (wr_acc) begin
            state_q <= AX_RESP_B;
            pend_q  <= 1'b1;
          end else if (rd_acc) begin
            state_q <= AX_READ;
            pend_q  <= 1'b1;
          end
        end
        AX_READ: begin
          if (gnt_i) pend_q <= 1'b0;
          // data arrives the cycle after the grant
          if (rsp_i.valid) state_q <= AX_RESP_R;
        end
        AX_RESP_R: begin
          if (rready_i) state_q <= AX_IDLE;
        end
        AX_RESP_B: begin
          if (gnt_i) pend_q <= 1'b0;
          if (bvalid_o && bready_i) state_q <= AX_IDLE;
        end
        default: state_q <= AX_IDLE;
      endcase
    end
  end

  // latched address and data
  always_ff @(posedge clk) begin
    if (wr_acc) begin
      we_q    <= 1'b1;
      addr_q  <= awaddr_i[2 +: `FETCH_MEM_AW];
      wdata_q <= wdata_i;
    end else if (rd_acc) begin
      we_q   <= 1'b0;
      addr_q <= araddr_i[2 +: `FETCH_MEM_AW];
    end
    if ((state_q == AX_READ) && rsp_i.valid) begin
      rdata_q <= rsp_i.data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/prefetch_buffer.sv ====
/*
  sequential word fetcher with a small FIFO of words and their addresses
  at most one read in flight, FIFO depth must be a power of two
  a branch clears the FIFO at once, a read granted in that cycle is dropped
*/
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module prefetch_buffer import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        fetch_enable_i,
  input  logic        branch_i,
  input  logic [31:0] branch_addr_i,
  output mem_req_t    req_o,
  input  logic        gnt_i,
  input  mem_rsp_t    rsp_i,
  output logic        word_valid_o,
  output logic [31:0] word_data_o,
  output logic [31:0] word_addr_o,
  input  logic        word_pop_i
);

  localparam int unsigned DEPTH = `FETCH_PF_DEPTH;
  localparam int unsigned PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CW    = $clog2(DEPTH + 1);

  logic [31:0]   fifo_data_q [DEPTH];
  logic [31:0]   fifo_addr_q [DEPTH];
  logic [PW-1:0] rd_ptr_q, wr_ptr_q;
  logic [CW-1:0] count_q;
  logic [CW:0]   occupied;
  // byte address of the next word to fetch
  logic [31:0]   fetch_addr_q;
  // address of the read in flight
  logic [31:0]   rsp_addr_q;
  logic          inflight_q;
  logic          drop_q;
  logic          issue;
  logic          push;
  logic          pop;

  ////////////////////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////////////////////

  // an in-flight read already owns a FIFO slot
  assign occupied = count_q + inflight_q;
  assign issue    = fetch_enable_i && (occupied < DEPTH);

  assign req_o.valid = issue;
  assign req_o.we    = 1'b0;
  assign req_o.addr  = fetch_addr_q[2 +: `FETCH_MEM_AW];
  assign req_o.wdata = '0;

  // stale data from before the branch never lands
  assign push = rsp_i.valid && !drop_q && !branch_i;
  assign pop  = word_pop_i && word_valid_o && !branch_i;

  ////////////////////////////////////////////////////////////////////////////
  // FIFO control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_addr_q <= `FETCH_BOOT_ADDR & 32'hffff_fffc;
      rd_ptr_q     <= '0;
      wr_ptr_q     <= '0;
      count_q      <= '0;
      inflight_q   <= 1'b0;
      drop_q       <= 1'b0;
    end else begin
      // memory answers exactly one cycle after the grant
      inflight_q <= issue && gnt_i;
      drop_q     <= branch_i && issue && gnt_i;
      if (branch_i) begin
        // restart at the word holding the target
        fetch_addr_q <= {branch_addr_i[31:2], 2'b00};
        rd_ptr_q     <= '0;
        wr_ptr_q     <= '0;
        count_q      <= '0;
      end else begin
        if (issue && gnt_i) fetch_addr_q <= fetch_addr_q + 32'd4;
        if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
        if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
        case ({push, pop})
          2'b10:   count_q <= count_q + 1'b1;
          2'b01:   count_q <= count_q - 1'b1;
          default: count_q <= count_q;
        endcase
      end
    end
  end

  // word storage
  always_ff @(posedge clk) begin
    if (issue && gnt_i) rsp_addr_q <= fetch_addr_q;
    if (push) begin
      fifo_data_q[wr_ptr_q] <= rsp_i.data;
      fifo_addr_q[wr_ptr_q] <= rsp_addr_q;
    end
  end

  // head of the FIFO towards the aligner
  assign word_valid_o = (count_q != '0);
  assign word_data_o  = fifo_data_q[rd_ptr_q];
  assign word_addr_o  = fifo_addr_q[rd_ptr_q];

endmodule

`default_nettype wire

// ==== hw/instr_aligner.sv ====
/*
  splits fetched words into 16- and 32-bit instructions with their pc
  a compressed instruction is zero-extended, not expanded
  output is combinational from the FIFO head and the residue
  no packet is offered in a branch cycle
*/
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module instr_aligner import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        word_valid_i,
  input  logic [31:0] word_data_i,
  output logic        word_pop_o,
  input  logic        branch_i,
  input  logic [31:0] branch_addr_i,
  output instr_pkt_t  instr_o,
  output logic        instr_valid_o,
  input  logic        id_ready_i
);

  align_state_e state_q, state_d;
  logic [31:0]  pc_q, pc_d;
  // saved upper half of an already popped word
  logic [15:0]  res_q, res_d;
  logic         lo_is32;
  logic         hi_is32;
  logic         take;

  // low two bits both set means a 32-bit instruction
  assign lo_is32 = (word_data_i[1:0] == 2'b11);
  assign hi_is32 = (word_data_i[17:16] == 2'b11);
  assign take    = word_valid_i && id_ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // next state and output
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d            = state_q;
    pc_d               = pc_q;
    res_d              = res_q;
    instr_o.instr      = word_data_i;
    instr_o.pc         = pc_q;
    instr_o.compressed = 1'b0;
    instr_valid_o      = 1'b0;
    word_pop_o         = 1'b0;

    case (state_q)
      ALIGNED: begin
        instr_valid_o = word_valid_i;
        if (lo_is32) begin
          // whole word is one instruction
          if (take) begin
            pc_d       = pc_q + 32'd4;
            word_pop_o = 1'b1;
          end
        end else begin
          instr_o.instr      = {16'h0000, word_data_i[15:0]};
          instr_o.compressed = 1'b1;
          // keep the upper half, the word itself goes
          if (take) begin
            pc_d       = pc_q + 32'd2;
            word_pop_o = 1'b1;
            res_d      = word_data_i[31:16];
            state_d    = hi_is32 ? RESIDUE32 : RESIDUE16;
          end
        end
      end

      RESIDUE16: begin
        // needs no word, the residue is complete
        instr_valid_o      = 1'b1;
        instr_o.instr      = {16'h0000, res_q};
        instr_o.compressed = 1'b1;
        if (id_ready_i) begin
          pc_d    = pc_q + 32'd2;
          state_d = ALIGNED;
        end
      end

      RESIDUE32: begin
        // crosses a word: residue low, next word's low half high
        instr_valid_o = word_valid_i;
        instr_o.instr = {word_data_i[15:0], res_q};
        if (take) begin
          pc_d       = pc_q + 32'd4;
          word_pop_o = 1'b1;
          res_d      = word_data_i[31:16];
          state_d    = hi_is32 ? RESIDUE32 : RESIDUE16;
        end
      end

      BRANCH_HALF: begin
        if (hi_is32) begin
          // first half of a crossing instruction, nothing to show yet
          if (word_valid_i) begin
            word_pop_o = 1'b1;
            res_d      = word_data_i[31:16];
            state_d    = RESIDUE32;
          end
        end else begin
          instr_valid_o      = word_valid_i;
          instr_o.instr      = {16'h0000, word_data_i[31:16]};
          instr_o.compressed = 1'b1;
          if (take) begin
            pc_d       = pc_q + 32'd2;
            word_pop_o = 1'b1;
            state_d    = ALIGNED;
          end
        end
      end

      default: state_d = ALIGNED;
    endcase

    // redirect overrides everything, bit 1 says which half to start in
    if (branch_i) begin
      instr_valid_o = 1'b0;
      word_pop_o    = 1'b0;
      pc_d          = branch_addr_i;
      state_d       = branch_addr_i[1] ? BRANCH_HALF : ALIGNED;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ALIGNED;
      pc_q    <= `FETCH_BOOT_ADDR;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
    end
  end

  always_ff @(posedge clk) begin
    res_q <= res_d;
  end

endmodule

`default_nettype wire

// ==== hw/fetch_top.sv ====
/*
  fetch front end: host AXI4-Lite port and prefetcher share one memory
  host has priority on the memory port
  branch_addr_i must be even
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  // host AXI4-Lite slave
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [31:0] awaddr_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  input  logic [31:0] wdata_i,
  output logic        bvalid_o,
  input  logic        bready_i,
  output logic [1:0]  bresp_o,
  input  logic        arvalid_i,
  output logic        arready_o,
  input  logic [31:0] araddr_i,
  output logic        rvalid_o,
  input  logic        rready_i,
  output logic [31:0] rdata_o,
  output logic [1:0]  rresp_o,
  // fetch control and decode side
  input  logic        fetch_enable_i,
  input  logic        branch_i,
  input  logic [31:0] branch_addr_i,
  output instr_pkt_t  instr_o,
  output logic        instr_valid_o,
  input  logic        id_ready_i
);

  mem_req_t    host_req, fetch_req, mem_req;
  mem_rsp_t    host_rsp, fetch_rsp, mem_rsp;
  logic        host_gnt, fetch_gnt;
  logic        word_valid, word_pop;
  logic [31:0] word_data;

  axil_mem_port u_axil_mem_port (
    .*,
    .req_o (host_req),
    .gnt_i (host_gnt),
    .rsp_i (host_rsp)
  );

  mem_arbiter u_mem_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .host_req_i  (host_req),
    .fetch_req_i (fetch_req),
    .host_gnt_o  (host_gnt),
    .fetch_gnt_o (fetch_gnt),
    .host_rsp_o  (host_rsp),
    .fetch_rsp_o (fetch_rsp),
    .mem_req_o   (mem_req),
    .mem_rsp_i   (mem_rsp)
  );

  instr_mem u_instr_mem (
    .clk   (clk),
    .req_i (mem_req),
    .rsp_o (mem_rsp)
  );

  // word address is kept for debug, the aligner tracks its own pc
  prefetch_buffer u_prefetch_buffer (
    .*,
    .req_o        (fetch_req),
    .gnt_i        (fetch_gnt),
    .rsp_i        (fetch_rsp),
    .word_valid_o (word_valid),
    .word_data_o  (word_data),
    .word_addr_o  (),
    .word_pop_i   (word_pop)
  );

  instr_aligner u_instr_aligner (
    .*,
    .word_valid_i (word_valid),
    .word_data_i  (word_data),
    .word_pop_o   (word_pop)
  );

endmodule

`default_nettype wire

// ==== tests/fetch_assertions.sv ====
/*
  protocol checks on the aligner output, bound into instr_aligner
  fail_count holds the number of failed checks so far
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_assertions import fetch_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input logic        instr_valid_i,
  input logic        id_ready_i,
  input logic        branch_i,
  input instr_pkt_t  instr_i,
  input logic [31:0] pc_i
);

  int fail_count = 0;

  // nothing offered to decode while reset is held
  valid_in_reset: assert property (@(posedge clk) !rst_n |-> !instr_valid_i)
    else begin
      fail_count = fail_count + 1;
      $error("instr_valid_o high during reset");
    end

  // a stalled packet holds until taken, only a redirect may withdraw it
  hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
      (instr_valid_i && !id_ready_i && !branch_i)
      |=> (branch_i || (instr_valid_i && $stable(instr_i))))
    else begin
      fail_count = fail_count + 1;
      $error("instr_o changed while stalled");
    end

  // halfword granularity, pc never odd
  pc_even: assert property (@(posedge clk) disable iff (!rst_n) !pc_i[0])
    else begin
      fail_count = fail_count + 1;
      $error("aligner pc is odd");
    end

endmodule

bind instr_aligner fetch_assertions u_fetch_assertions (
  .clk           (clk),
  .rst_n         (rst_n),
  .instr_valid_i (instr_valid_o),
  .id_ready_i    (id_ready_i),
  .branch_i      (branch_i),
  .instr_i       (instr_o),
  .pc_i          (pc_q)
);

`default_nettype wire

// ==== tests/fetch_tb.sv ====
/*
  testbench for the fetch front end
  loads a random program over AXI4-Lite, then checks the instruction stream
  against a halfword model under stalls, branches and concurrent host reads
  memory depth must be a power of two and branch targets stay inside memory
*/
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_tb import fetch_pkg::*; ();

  localparam int DRV     = 2;
  localparam int TIMEOUT = 100;
  localparam int WORDS   = `FETCH_MEM_WORDS;
  localparam int N_RD    = 24;

  logic        clk;
  logic        rst_n;
  logic        awvalid_i, awready_o, wvalid_i, wready_o, bvalid_o, bready_i;
  logic        arvalid_i, arready_o, rvalid_o, rready_i;
  logic [31:0] awaddr_i, wdata_i, araddr_i, rdata_o;
  logic [1:0]  bresp_o, rresp_o;
  logic        fetch_enable_i, branch_i, id_ready_i, instr_valid_o;
  logic [31:0] branch_addr_i;
  instr_pkt_t  instr_o;

  integer      seed = 25742;
  // reference copy of the memory contents
  logic [31:0] image [WORDS];
  logic [31:0] model_pc;
  logic [31:0] rdata;
  int          idx;
  int          rd_idx [N_RD];
  int          rd_gap [N_RD];

  fetch_top u_fetch_top (.*);

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // reporting and compare
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_instr(input instr_pkt_t exp, input instr_pkt_t act);
    string msg;
    if (act !== exp) begin
      msg = $sformatf("mismatch at %0t: instr_o expected pc=%h instr=%h c=%b,",
                      $time, exp.pc, exp.instr, exp.compressed);
      msg = {msg, $sformatf(" got pc=%h instr=%h c=%b", act.pc, act.instr, act.compressed)};
      stop_run(msg);
    end
  endtask

  task automatic check_word(input logic [31:0] exp, input logic [31:0] act, input string name);
    if (act !== exp) begin
      stop_run($sformatf("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_resp(input logic [1:0] exp, input logic [1:0] act, input string name);
    if (act !== exp) begin
      stop_run($sformatf("mismatch at %0t: %s expected %b, got %b", $time, name, exp, act));
    end
  endtask

  // a failed aligner assertion stops the run on the next falling edge
  always @(negedge clk) begin
    if (u_fetch_top.u_instr_aligner.u_fetch_assertions.fail_count != 0) begin
      stop_run("an assertion in the aligner failed");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // halfword model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] half_at(input logic [31:0] addr);
    logic [31:0] w;
    // memory wraps at its size just like the fetcher's word address
    w = image[addr[2 +: `FETCH_MEM_AW]];
    return addr[1] ? w[31:16] : w[15:0];
  endfunction

  function automatic instr_pkt_t predict(input logic [31:0] pc);
    instr_pkt_t  p;
    logic [15:0] lo;
    lo   = half_at(pc);
    p.pc = pc;
    if (lo[1:0] == 2'b11) begin
      p.instr      = {half_at(pc + 32'd2), lo};
      p.compressed = 1'b0;
    end else begin
      p.instr      = {16'h0000, lo};
      p.compressed = 1'b1;
    end
    return p;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // host port
  ////////////////////////////////////////////////////////////////////////////

  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
    int t;
    @(posedge clk);
    #DRV;
    awvalid_i = 1'b1;
    awaddr_i  = addr;
    wvalid_i  = 1'b1;
    wdata_i   = data;
    bready_i  = 1'b1;
    t = 0;
    @(negedge clk);
    while (!(awready_o && wready_o)) begin
      t++;
      if (t > TIMEOUT) stop_run("write address and data were never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    #DRV;
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    t = 0;
    @(negedge clk);
    while (!bvalid_o) begin
      t++;
      if (t > TIMEOUT) stop_run("write response never arrived");
      @(negedge clk);
    end
    // OKAY is the only response the port gives
    check_resp(2'b00, bresp_o, "bresp_o");
    @(posedge clk);
    #DRV;
    bready_i = 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
    int t;
    @(posedge clk);
    #DRV;
    arvalid_i = 1'b1;
    araddr_i  = addr;
    rready_i  = 1'b1;
    t = 0;
    @(negedge clk);
    while (!arready_o) begin
      t++;
      if (t > TIMEOUT) stop_run("read address was never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    #DRV;
    arvalid_i = 1'b0;
    t = 0;
    @(negedge clk);
    while (!rvalid_o) begin
      t++;
      if (t > TIMEOUT) stop_run("read data never arrived");
      @(negedge clk);
    end
    data = rdata_o;
    check_resp(2'b00, rresp_o, "rresp_o");
    @(posedge clk);
    #DRV;
    rready_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // instruction stream with random stalls and branches
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_stream(input int n, input int ready_pct, input int branch_pct);
    int         got;
    int         idle;
    instr_pkt_t exp;
    got  = 0;
    idle = 0;
    while (got < n) begin
      @(posedge clk);
      #DRV;
      id_ready_i    = int'({$random(seed)} % 100) < ready_pct;
      branch_i      = int'({$random(seed)} % 100) < branch_pct;
      branch_addr_i = $random(seed) & (WORDS * 4 - 2);
      // sampled mid-cycle while the transfer itself happens on the next edge
      @(negedge clk);
      if (branch_i) begin
        model_pc = branch_addr_i;
      end else if (instr_valid_o && id_ready_i) begin
        exp = predict(model_pc);
        check_instr(exp, instr_o);
        model_pc = model_pc + (exp.compressed ? 32'd2 : 32'd4);
        got++;
        idle = 0;
      end else begin
        idle++;
        if (idle > TIMEOUT) stop_run("no instruction delivered for too many cycles");
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    awvalid_i      = 1'b0;
    awaddr_i       = '0;
    wvalid_i       = 1'b0;
    wdata_i        = '0;
    bready_i       = 1'b0;
    arvalid_i      = 1'b0;
    araddr_i       = '0;
    rready_i       = 1'b0;
    fetch_enable_i = 1'b0;
    branch_i       = 1'b0;
    branch_addr_i  = '0;
    id_ready_i     = 1'b0;
    model_pc       = `FETCH_BOOT_ADDR;
    for (int k = 0; k < WORDS; k++) begin
      image[k] = $random(seed);
    end
    repeat (3) @(posedge clk);
    #DRV;
    rst_n = 1'b1;

    // program load and readback while the fetcher is still idle
    for (int k = 0; k < WORDS; k++) begin
      axi_write(k * 4, image[k]);
    end
    for (int k = 0; k < 32; k++) begin
      idx = {$random(seed)} % WORDS;
      axi_read(idx * 4, rdata);
      check_word(image[idx], rdata, "rdata_o");
    end

    @(posedge clk);
    #DRV;
    fetch_enable_i = 1'b1;
    // free flow followed by stalls and then by stalls with redirects
    run_stream(200, 100, 0);
    run_stream(300, 50, 0);
    run_stream(400, 60, 5);

    // host reads competing with the fetcher for the memory port
    for (int k = 0; k < N_RD; k++) begin
      rd_idx[k] = {$random(seed)} % WORDS;
      rd_gap[k] = {$random(seed)} % 8;
    end
    fork
      run_stream(400, 70, 4);
      begin
        for (int k = 0; k < N_RD; k++) begin
          repeat (rd_gap[k]) @(posedge clk);
          axi_read(rd_idx[k] * 4, rdata);
          check_word(image[rd_idx[k]], rdata, "rdata_o");
        end
      end
    join

    if (u_fetch_top.u_instr_aligner.u_fetch_assertions.fail_count == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      stop_run("an assertion in the aligner failed during the run");
    end
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
hw/fetch_pkg.sv
hw/instr_mem.sv
hw/mem_arbiter.sv
hw/axil_mem_port.sv
hw/prefetch_buffer.sv
hw/instr_aligner.sv
hw/fetch_top.sv
tests/fetch_assertions.sv
tests/fetch_tb.sv
